//--- include/safety_bus_cfg.svh
`ifndef SAFETY_BUS_CFG_SVH
`define SAFETY_BUS_CFG_SVH

// ----------------------------------------
// Address map
// ----------------------------------------

// Bytes per SRAM bank, bank 1 sits right above bank 0
`define SAFETY_BANK_BYTES 1024

`define SAFETY_BANK0_BASE 32'h0000_0000

// SoC control block
`define SAFETY_CTRL_BASE  32'h0000_1000
`define SAFETY_CTRL_RANGE 32'h0000_0100

// ----------------------------------------
// Reset values and patterns
// ----------------------------------------

`define SAFETY_BOOT_ADDR_RESET 32'h0000_0080

// Returned for any unmapped access
`define SAFETY_ERR_RDATA 32'hBADC_AB1E

`endif

//--- safety_bus.f
+incdir+include
source/safety_bus_pkg.sv
source/safety_ctrl_pkg.sv
source/bus_req_if.sv
source/safety_addr_decode.sv
source/safety_mem_bank.sv
source/safety_soc_ctrl.sv
source/safety_resp_return.sv
source/safety_bus_top.sv
tests/safety_bus_tb.sv

//--- source/bus_req_if.sv
`timescale 1ns/1ps

interface bus_req_if;

  logic                      req;
  logic                      we;
  safety_bus_pkg::be_t       be;
  safety_bus_pkg::addr_t     addr;
  safety_bus_pkg::data_t     wdata;
  // Target chosen by the address decode
  safety_bus_pkg::target_e   target;

  modport dec (
    output req,
    output we,
    output be,
    output addr,
    output wdata,
    output target
  );

  modport tgt (
    input req,
    input we,
    input be,
    input addr,
    input wdata,
    input target
  );

endinterface

//--- source/safety_addr_decode.sv
`timescale 1ns/1ps
`include "safety_bus_cfg.svh"

module safety_addr_decode (
  input  logic                  req_i,
  input  logic                  we_i,
  input  safety_bus_pkg::be_t   be_i,
  input  safety_bus_pkg::addr_t addr_i,
  input  safety_bus_pkg::data_t wdata_i,
  bus_req_if.dec                req
);

  // ----------------------------------------
  // Range bounds, upper bounds exclusive
  // ----------------------------------------

  localparam safety_bus_pkg::addr_t bank0_lo = `SAFETY_BANK0_BASE;
  localparam safety_bus_pkg::addr_t bank1_lo = `SAFETY_BANK0_BASE + `SAFETY_BANK_BYTES;
  localparam safety_bus_pkg::addr_t bank1_hi = `SAFETY_BANK0_BASE + 2 * `SAFETY_BANK_BYTES;
  localparam safety_bus_pkg::addr_t ctrl_lo  = `SAFETY_CTRL_BASE;
  localparam safety_bus_pkg::addr_t ctrl_hi  = `SAFETY_CTRL_BASE + `SAFETY_CTRL_RANGE;

  safety_bus_pkg::target_e target;

  always_comb begin
    // Anything not matched lands on the error target
    target = safety_bus_pkg::tgt_error;
    if (addr_i >= bank0_lo && addr_i < bank1_lo) begin
      target = safety_bus_pkg::tgt_bank0;
    end else if (addr_i >= bank1_lo && addr_i < bank1_hi) begin
      target = safety_bus_pkg::tgt_bank1;
    end else if (addr_i >= ctrl_lo && addr_i < ctrl_hi) begin
      target = safety_bus_pkg::tgt_ctrl;
    end
  end

  // ----------------------------------------
  // Decoded request
  // ----------------------------------------

  assign req.req    = req_i;
  assign req.we     = we_i;
  assign req.be     = be_i;
  assign req.addr   = addr_i;
  assign req.wdata  = wdata_i;
  assign req.target = target;

endmodule

//--- source/safety_bus_pkg.sv
package safety_bus_pkg;

  // ----------------------------------------
  // Request fields
  // ----------------------------------------

  // Byte address
  typedef logic [31:0] addr_t;

  // Data word
  typedef logic [31:0] data_t;

  // One enable per byte of a word
  typedef logic [3:0] be_t;

  // ----------------------------------------
  // Targets of the address map
  // ----------------------------------------

  // Error target is the default for unmapped addresses
  typedef enum logic [1:0] {
    tgt_error = 2'd0,
    tgt_bank0 = 2'd1,
    tgt_bank1 = 2'd2,
    tgt_ctrl  = 2'd3
  } target_e;

endpackage

//--- source/safety_bus_top.sv
`timescale 1ns/1ps

module safety_bus_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Request port
  input  logic                       req_i,
  input  logic                       we_i,
  input  safety_bus_pkg::be_t        be_i,
  input  safety_bus_pkg::addr_t      addr_i,
  input  safety_bus_pkg::data_t      wdata_i,

  input  safety_ctrl_pkg::bootmode_e bootmode_i,

  // Response port
  output logic                       rvalid_o,
  output safety_bus_pkg::data_t      rdata_o,
  output logic                       err_o,

  // Boot control
  output logic                       fetch_enable_o,
  output safety_bus_pkg::addr_t      boot_addr_o
);

  safety_bus_pkg::data_t bank0_rdata;
  safety_bus_pkg::data_t bank1_rdata;
  safety_bus_pkg::data_t ctrl_rdata;
  logic                  ctrl_err;

  bus_req_if req_bus ();

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  safety_addr_decode i_addr_decode (
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .be_i    ( be_i    ),
    .addr_i  ( addr_i  ),
    .wdata_i ( wdata_i ),
    .req     ( req_bus )
  );

  // ----------------------------------------
  // Targets
  // ----------------------------------------

  safety_mem_bank #(
    .bank_target ( safety_bus_pkg::tgt_bank0 )
  ) i_bank0 (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .req     ( req_bus     ),
    .rdata_o ( bank0_rdata )
  );

  safety_mem_bank #(
    .bank_target ( safety_bus_pkg::tgt_bank1 )
  ) i_bank1 (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .req     ( req_bus     ),
    .rdata_o ( bank1_rdata )
  );

  safety_soc_ctrl i_soc_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req            ( req_bus        ),
    .bootmode_i     ( bootmode_i     ),
    .rdata_o        ( ctrl_rdata     ),
    .err_o          ( ctrl_err       ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  // Response return, includes the error target
  safety_resp_return i_resp_return (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .req           ( req_bus     ),
    .bank0_rdata_i ( bank0_rdata ),
    .bank1_rdata_i ( bank1_rdata ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .ctrl_err_i    ( ctrl_err    ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       ),
    .rdata_o       ( rdata_o     )
  );

endmodule

//--- source/safety_ctrl_pkg.sv
package safety_ctrl_pkg;

  // Boot source sampled right after reset
  typedef enum logic [1:0] {
    boot_jtag    = 2'd0,
    boot_preload = 2'd1,
    boot_flash   = 2'd2
  } bootmode_e;

  // ----------------------------------------
  // Register map, word offsets
  // ----------------------------------------

  // 0x0 boot address, 0x4 fetch enable, 0x8 boot mode
  typedef enum logic [1:0] {
    reg_bootaddr = 2'd0,
    reg_fetchen  = 2'd1,
    reg_bootmode = 2'd2
  } ctrl_reg_e;

endpackage

//--- source/safety_mem_bank.sv
`timescale 1ns/1ps
`include "safety_bus_cfg.svh"

module safety_mem_bank #(
  parameter safety_bus_pkg::target_e bank_target = safety_bus_pkg::tgt_bank0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  bus_req_if.tgt                req,
  output safety_bus_pkg::data_t rdata_o
);

  localparam int unsigned num_words = `SAFETY_BANK_BYTES / 4;
  localparam int unsigned idx_width = $clog2(num_words);

  safety_bus_pkg::data_t mem_q [num_words];
  safety_bus_pkg::data_t rdata_q;
  logic [idx_width-1:0]  word_idx;
  logic                  sel;

  assign sel = req.req && (req.target == bank_target);

  // Word index from the byte offset inside the bank
  assign word_idx = req.addr[idx_width+1:2];

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (sel && req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // One cycle read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sel && !req.we) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- source/safety_resp_return.sv
`timescale 1ns/1ps
`include "safety_bus_cfg.svh"

module safety_resp_return (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  bus_req_if.tgt                req,
  input  safety_bus_pkg::data_t bank0_rdata_i,
  input  safety_bus_pkg::data_t bank1_rdata_i,
  input  safety_bus_pkg::data_t ctrl_rdata_i,
  input  logic                  ctrl_err_i,
  output logic                  rvalid_o,
  output logic                  err_o,
  output safety_bus_pkg::data_t rdata_o
);

  logic                    rvalid_q;
  safety_bus_pkg::target_e target_q;

  // ----------------------------------------
  // Response tracking
  // ----------------------------------------

  // Every request is accepted, response follows one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      target_q <= safety_bus_pkg::tgt_error;
    end else begin
      rvalid_q <= req.req;
      if (req.req) begin
        target_q <= req.target;
      end
    end
  end

  // ----------------------------------------
  // Data select and error target
  // ----------------------------------------

  always_comb begin
    case (target_q)
      safety_bus_pkg::tgt_bank0: begin
        rdata_o = bank0_rdata_i;
        err_o   = 1'b0;
      end
      safety_bus_pkg::tgt_bank1: begin
        rdata_o = bank1_rdata_i;
        err_o   = 1'b0;
      end
      safety_bus_pkg::tgt_ctrl: begin
        rdata_o = ctrl_rdata_i;
        err_o   = ctrl_err_i;
      end
      default: begin
        // Unmapped address
        rdata_o = `SAFETY_ERR_RDATA;
        err_o   = 1'b1;
      end
    endcase
  end

  assign rvalid_o = rvalid_q;

endmodule

//--- source/safety_soc_ctrl.sv
`timescale 1ns/1ps
`include "safety_bus_cfg.svh"

module safety_soc_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  bus_req_if.tgt                     req,
  input  safety_ctrl_pkg::bootmode_e bootmode_i,
  output safety_bus_pkg::data_t      rdata_o,
  output logic                       err_o,
  output logic                       fetch_enable_o,
  output safety_bus_pkg::addr_t      boot_addr_o
);

  localparam int unsigned off_width = $clog2(`SAFETY_CTRL_RANGE);

  logic                       first_cycle_q;
  safety_ctrl_pkg::bootmode_e bootmode_q;
  logic                       fetchen_q;
  safety_bus_pkg::addr_t      boot_addr_q;
  safety_bus_pkg::data_t      rdata_d;
  safety_bus_pkg::data_t      rdata_q;
  logic                       err_d;
  logic                       err_q;
  logic                       wr_bootaddr;
  logic                       wr_fetchen;
  logic                       sel;
  safety_ctrl_pkg::ctrl_reg_e reg_idx;

  assign sel     = req.req && (req.target == safety_bus_pkg::tgt_ctrl);
  assign reg_idx = safety_ctrl_pkg::ctrl_reg_e'(req.addr[3:2]);

  // ----------------------------------------
  // Register access decode
  // ----------------------------------------

  always_comb begin
    rdata_d     = '0;
    err_d       = 1'b0;
    wr_bootaddr = 1'b0;
    wr_fetchen  = 1'b0;
    if (req.addr[off_width-1:4] != '0) begin
      err_d = 1'b1;
    end else begin
      case (reg_idx)
        safety_ctrl_pkg::reg_bootaddr: begin
          rdata_d     = boot_addr_q;
          wr_bootaddr = sel && req.we;
        end
        safety_ctrl_pkg::reg_fetchen: begin
          rdata_d    = {31'b0, fetchen_q};
          wr_fetchen = sel && req.we && req.be[0];
        end
        safety_ctrl_pkg::reg_bootmode: begin
          // Read-only, writes are rejected
          if (req.we) begin
            err_d = 1'b1;
          end else begin
            rdata_d = {30'b0, bootmode_q};
          end
        end
        default: err_d = 1'b1;
      endcase
    end
  end

  // ----------------------------------------
  // Control registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      bootmode_q    <= safety_ctrl_pkg::boot_jtag;
      fetchen_q     <= 1'b0;
      boot_addr_q   <= `SAFETY_BOOT_ADDR_RESET;
    end else begin
      first_cycle_q <= 1'b0;
      if (first_cycle_q) begin
        bootmode_q <= bootmode_i;
        fetchen_q  <= (bootmode_i == safety_ctrl_pkg::boot_jtag);
      end
      // Bus write wins over the boot-time load
      if (wr_fetchen) begin
        fetchen_q <= req.wdata[0];
      end
      for (int b = 0; b < 4; b++) begin
        if (wr_bootaddr && req.be[b]) begin
          boot_addr_q[8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (sel) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign rdata_o        = rdata_q;
  assign err_o          = err_q;
  assign fetch_enable_o = fetchen_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

//--- tests/safety_bus_tb.sv
`timescale 1ns/1ps
`include "safety_bus_cfg.svh"

module safety_bus_tb;

  localparam int num_reqs   = 2000;
  localparam int max_cycles = num_reqs + 50;
  localparam int bank_words = `SAFETY_BANK_BYTES / 4;

  // Mask selects the bytes whose content is known
  typedef struct packed {
    logic                  has_data;
    logic                  err;
    safety_bus_pkg::data_t mask;
    safety_bus_pkg::data_t data;
  } exp_resp_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       req_i;
  logic                       we_i;
  safety_bus_pkg::be_t        be_i;
  safety_bus_pkg::addr_t      addr_i;
  safety_bus_pkg::data_t      wdata_i;
  safety_ctrl_pkg::bootmode_e bootmode_i;
  logic                       rvalid_o;
  safety_bus_pkg::data_t      rdata_o;
  logic                       err_o;
  logic                       fetch_enable_o;
  safety_bus_pkg::addr_t      boot_addr_o;

  integer                seed;
  int                    cycles;
  int                    num_checks;
  int                    num_errors;
  int                    checks0;
  int                    errors0;
  logic                  prev_req;
  exp_resp_t             exp_q [$];
  safety_bus_pkg::data_t mem_m [2][bank_words];
  safety_bus_pkg::data_t vld_m [2][bank_words];
  safety_bus_pkg::addr_t boot_m;
  logic                  fetch_m;

  safety_bus_top dut_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .be_i           ( be_i           ),
    .addr_i         ( addr_i         ),
    .wdata_i        ( wdata_i        ),
    .bootmode_i     ( bootmode_i     ),
    .rvalid_o       ( rvalid_o       ),
    .rdata_o        ( rdata_o        ),
    .err_o          ( err_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Timeout: run went past %0d cycles", max_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_data(input string name, input safety_bus_pkg::data_t exp,
                            input safety_bus_pkg::data_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("Fail %s: expected err %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input safety_bus_pkg::addr_t exp,
                            input safety_bus_pkg::addr_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %s finished: %0d checks, %0d errors", name,
             num_checks - checks0, num_errors - errors0);
    checks0 = num_checks;
    errors0 = num_errors;
  endtask

  // Response to the request driven one cycle earlier
  task automatic check_response(input string name);
    exp_resp_t e;
    num_checks++;
    if (rvalid_o !== prev_req) begin
      num_errors++;
      if (prev_req)
        $display("Error in %s: a request got no response in the next cycle", name);
      else
        $display("Error in %s: a response came without a request", name);
    end
    if (prev_req && exp_q.size() > 0) begin
      e = exp_q.pop_front();
      if (rvalid_o === 1'b1) begin
        check_err({name, " err"}, e.err, err_o);
        if (e.has_data)
          check_data({name, " rdata"}, e.data & e.mask, rdata_o & e.mask);
      end
    end
  endtask

  // ----------------------------------------
  // Random request and reference model
  // ----------------------------------------

  task automatic drive_request();
    exp_resp_t             e;
    int                    kind;
    int                    bank;
    int                    word;
    int                    ofs;
    logic                  w;
    safety_bus_pkg::be_t   be;
    safety_bus_pkg::data_t wd;
    safety_bus_pkg::addr_t a;
    w    = $random(seed);
    be   = $random(seed);
    wd   = $random(seed);
    kind = {$random(seed)} % 10;
    e    = '0;
    e.has_data = !w;
    e.mask     = '1;
    if (kind < 7) begin
      bank = (kind < 4) ? 0 : 1;
      word = {$random(seed)} % bank_words;
      a    = `SAFETY_BANK0_BASE + bank * `SAFETY_BANK_BYTES + word * 4;
      e.data = mem_m[bank][word];
      e.mask = vld_m[bank][word];
      for (int b = 0; b < 4; b++) begin
        if (w && be[b]) begin
          mem_m[bank][word][8*b +: 8] = wd[8*b +: 8];
          vld_m[bank][word][8*b +: 8] = 8'hff;
        end
      end
    end else if (kind < 9) begin
      ofs = {$random(seed)} % 5;
      if (ofs == 4) begin
        ofs = 4 + {$random(seed)} % 60;
      end
      a = `SAFETY_CTRL_BASE + ofs * 4;
      case (ofs)
        0: begin
          e.data = boot_m;
          for (int b = 0; b < 4; b++) begin
            if (w && be[b]) begin
              boot_m[8*b +: 8] = wd[8*b +: 8];
            end
          end
        end
        1: begin
          e.data = {31'b0, fetch_m};
          if (w && be[0]) begin
            fetch_m = wd[0];
          end
        end
        2: begin
          e.data = {30'b0, bootmode_i};
          e.err  = w;
        end
        default: e.err = 1'b1;
      endcase
    end else begin
      // Gap above bank 1, space above the control block or the upper half
      case ({$random(seed)} % 3)
        0: a = 32'h0000_0800 + {$random(seed)} % 32'h800;
        1: a = `SAFETY_CTRL_BASE + `SAFETY_CTRL_RANGE + {$random(seed)} % 32'h1000;
        default: a = {1'b1, 31'($random(seed))};
      endcase
      e.data = `SAFETY_ERR_RDATA;
      e.err  = 1'b1;
    end
    req_i   = 1'b1;
    we_i    = w;
    be_i    = be;
    addr_i  = {a[31:2], 2'b00};
    wdata_i = wd;
    exp_q.push_back(e);
    prev_req = 1'b1;
  endtask

  initial begin
    seed       = 64;
    cycles     = 0;
    num_checks = 0;
    num_errors = 0;
    checks0    = 0;
    errors0    = 0;
    prev_req   = 1'b0;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    be_i       = '0;
    addr_i     = '0;
    wdata_i    = '0;
    bootmode_i = safety_ctrl_pkg::bootmode_e'({$random(seed)} % 3);
    for (int i = 0; i < bank_words; i++) begin
      mem_m[0][i] = '0;
      mem_m[1][i] = '0;
      vld_m[0][i] = '0;
      vld_m[1][i] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_bit("reset_values rvalid", 1'b0, rvalid_o);
    // Mode is captured in the first cycle
    @(negedge clk_i);
    fetch_m = (bootmode_i == safety_ctrl_pkg::boot_jtag);
    boot_m  = `SAFETY_BOOT_ADDR_RESET;
    check_bit("reset_values rvalid", 1'b0, rvalid_o);
    check_bit("reset_values fetch_enable", fetch_m, fetch_enable_o);
    check_addr("reset_values boot_addr", boot_m, boot_addr_o);
    finish_test("reset_values");

    for (int i = 0; i < num_reqs; i++) begin
      check_response("random_requests");
      check_bit("random_requests fetch_enable", fetch_m, fetch_enable_o);
      check_addr("random_requests boot_addr", boot_m, boot_addr_o);
      if (({$random(seed)} % 8) == 0) begin
        req_i    = 1'b0;
        prev_req = 1'b0;
      end else begin
        drive_request();
      end
      @(negedge clk_i);
    end
    finish_test("random_requests");

    check_response("drain");
    req_i    = 1'b0;
    prev_req = 1'b0;
    @(negedge clk_i);
    check_response("drain");
    if (exp_q.size() != 0) begin
      num_errors++;
      $display("Error in drain: %0d expected responses never arrived", exp_q.size());
    end
    finish_test("drain");

    $display("Checks: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
